/* fb_config.svh */
`ifndef FB_CONFIG_SVH
`define FB_CONFIG_SVH

// video mode, small enough for quick simulation
`define FB_H_VISIBLE 16
`define FB_H_FRONT 2
`define FB_H_SYNC 3
`define FB_H_BACK 3
`define FB_V_VISIBLE 8
`define FB_V_FRONT 1
`define FB_V_SYNC 2
`define FB_V_BACK 1

// H_VISIBLE must divide evenly into the stripes
`define FB_NUM_STRIPES 2
`define FB_ADC_BITS 5
`define FB_COLOR_BITS 4

`endif

/* fb_pkg.sv */
`include "fb_config.svh"

package fb_pkg;

  // screen coordinates
  typedef logic [$clog2(`FB_H_VISIBLE)-1:0] fb_x_t;
  typedef logic [$clog2(`FB_V_VISIBLE)-1:0] fb_y_t;

  // column inside one stripe, and the word address of a stripe bank
  typedef logic [$clog2(`FB_H_VISIBLE / `FB_NUM_STRIPES)-1:0] fb_sx_t;
  typedef logic [$bits(fb_y_t) + $bits(fb_sx_t)-1:0] fb_addr_t;

  typedef logic [`FB_COLOR_BITS-1:0] color_t;

  typedef struct packed {
    color_t red;
    color_t grn;
    color_t blu;
  } pixel_t;

  typedef logic [`FB_ADC_BITS-1:0] adc_t;

  typedef enum logic {
    src_clear,
    src_draw
  } src_state_e;

endpackage

/* gfx_if.sv */
// one pixel write, valid/ready handshake
interface gfx_if import fb_pkg::*; ();

  logic   valid;
  logic   ready;
  fb_x_t  x;
  fb_y_t  y;
  pixel_t color;

  modport src(
    output valid, x, y, color,
    input ready
  );

  modport snk(
    input valid, x, y, color,
    output ready
  );

endinterface

/* gfx_clear.sv */
`include "fb_config.svh"

module gfx_clear import fb_pkg::*; (
  input  logic clk,
  input  logic reset,
  gfx_if.src   pix,
  output logic last
);

  localparam fb_x_t x_max = fb_x_t'(`FB_H_VISIBLE - 1);
  localparam fb_y_t y_max = fb_y_t'(`FB_V_VISIBLE - 1);

  fb_x_t x;
  fb_y_t y;
  logic  busy;

  // raster walk, one step per accepted write
  always_ff @(posedge clk) begin
    if (reset) begin
      x    <= '0;
      y    <= '0;
      busy <= 1'b1;
    end else if (busy && pix.ready) begin
      if (last) begin
        busy <= 1'b0;
      end else if (x == x_max) begin
        x <= '0;
        y <= y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  assign last      = busy && (x == x_max) && (y == y_max);
  assign pix.valid = busy;
  assign pix.x     = x;
  assign pix.y     = y;
  assign pix.color = '0;

  // once idle, stays idle until reset
  assert property (@(posedge clk) disable iff (reset) !pix.valid |=> !pix.valid);

endmodule

/* point_source.sv */
`include "fb_config.svh"

module point_source import fb_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  gfx_if.snk         clear,
  input  logic       adc_valid,
  input  adc_t       adc_x,
  input  adc_t       adc_y,
  input  logic [2:0] adc_rgb,
  output logic       adc_ready,
  input  logic       clear_last,
  gfx_if.src         draw,
  output logic       scan_enable
);

  src_state_e state;

  // one-entry output register
  logic   out_valid;
  fb_x_t  out_x;
  fb_y_t  out_y;
  pixel_t out_color;

  adc_t   x_inv;
  fb_x_t  map_x;
  fb_y_t  map_y;
  pixel_t map_color;
  logic   draw_fire;
  logic   adc_fire;

  // mirror the column, halve both axes
  assign x_inv         = ~adc_x;
  assign map_x         = fb_x_t'(x_inv >> 1);
  assign map_y         = fb_y_t'(adc_y >> 1);
  assign map_color.red = {`FB_COLOR_BITS{adc_rgb[2]}};
  assign map_color.grn = {`FB_COLOR_BITS{adc_rgb[1]}};
  assign map_color.blu = {`FB_COLOR_BITS{adc_rgb[0]}};

  always_comb begin
    if (state == src_clear) begin
      draw.valid = clear.valid;
      draw.x     = clear.x;
      draw.y     = clear.y;
      draw.color = clear.color;
    end else begin
      draw.valid = out_valid;
      draw.x     = out_x;
      draw.y     = out_y;
      draw.color = out_color;
    end
  end

  assign clear.ready = (state == src_clear) && draw.ready;
  assign draw_fire   = draw.valid && draw.ready;
  assign adc_ready   = (state == src_draw) && (!out_valid || draw_fire);
  assign adc_fire    = adc_valid && adc_ready;
  assign scan_enable = (state == src_draw);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= src_clear;
      out_valid <= 1'b0;
    end else begin
      if (state == src_clear && clear.valid && clear.ready && clear_last) begin
        state <= src_draw;
      end
      if (adc_fire) begin
        out_valid <= 1'b1;
      end else if (draw_fire) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (adc_fire) begin
      out_x     <= map_x;
      out_y     <= map_y;
      out_color <= map_color;
    end
  end

  // nothing is taken from the adc, and nothing is pending, while clearing
  assert property (@(posedge clk) disable iff (reset)
    state == src_clear |-> !adc_ready && !out_valid);

endmodule

/* stripe_router.sv */
`include "fb_config.svh"

module stripe_router import fb_pkg::*; (
  gfx_if.snk up,
  gfx_if.src banks [`FB_NUM_STRIPES]
);

  localparam int num_s    = `FB_NUM_STRIPES;
  localparam int sel_bits = (num_s > 1) ? $clog2(num_s) : 1;

  logic [sel_bits-1:0] sel;
  logic [num_s-1:0]    bank_valid;
  logic [num_s-1:0]    bank_ready;
  fb_x_t               col;

  // column x lives in bank x mod num_s, at stripe column x / num_s
  assign sel = sel_bits'(up.x % num_s);
  assign col = fb_x_t'(up.x / num_s);

  for (genvar i = 0; i < num_s; i++) begin : g_bank
    assign bank_valid[i]  = up.valid && (sel == i);
    assign banks[i].valid = bank_valid[i];
    assign banks[i].x     = col;
    assign banks[i].y     = up.y;
    assign banks[i].color = up.color;
    assign bank_ready[i]  = banks[i].ready;
  end

  // ready comes back from the owning bank only
  assign up.ready = bank_ready[sel];

  always_comb begin
    assert ($onehot0(bank_valid));
  end

endmodule

/* stripe_bank.sv */
`include "fb_config.svh"

module stripe_bank import fb_pkg::*; (
  input  logic     clk,
  gfx_if.snk       wr,
  input  logic     rd_en,
  input  fb_addr_t rd_addr,
  output pixel_t   rd_data
);

  localparam int depth = `FB_H_VISIBLE / `FB_NUM_STRIPES * `FB_V_VISIBLE;

  pixel_t   mem [depth];
  fb_addr_t wr_addr;

  // router already divided x down to the stripe column
  assign wr_addr  = {wr.y, fb_sx_t'(wr.x)};

  // single port, scanout wins
  assign wr.ready = !rd_en;

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end else if (wr.valid) begin
      mem[wr_addr] <= wr.color;
    end
  end

  // a write refused by scanout does not transfer and is still offered next cycle
  assert property (@(posedge clk)
    rd_en && wr.valid |-> !wr.ready ##1 wr.valid);

endmodule

/* scan_reader.sv */
`include "fb_config.svh"

module scan_reader import fb_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       scan_enable,
  output logic [`FB_NUM_STRIPES-1:0] rd_en,
  output fb_addr_t                   rd_addr,
  input  pixel_t                     rd_data [`FB_NUM_STRIPES],
  output color_t                     vga_red,
  output color_t                     vga_grn,
  output color_t                     vga_blu,
  output logic                       hsync,
  output logic                       vsync
);

  localparam int num_s    = `FB_NUM_STRIPES;
  localparam int sel_bits = (num_s > 1) ? $clog2(num_s) : 1;
  localparam int h_total  = `FB_H_VISIBLE + `FB_H_FRONT + `FB_H_SYNC + `FB_H_BACK;
  localparam int v_total  = `FB_V_VISIBLE + `FB_V_FRONT + `FB_V_SYNC + `FB_V_BACK;
  localparam int hs_start = `FB_H_VISIBLE + `FB_H_FRONT;
  localparam int vs_start = `FB_V_VISIBLE + `FB_V_FRONT;

  logic [$clog2(h_total)-1:0] h_cnt;
  logic [$clog2(v_total)-1:0] v_cnt;
  logic                       visible;
  logic                       hs0;
  logic                       vs0;
  logic [sel_bits-1:0]        sel;

  // stage 1 travels with the bank read
  logic                       vis_d1;
  logic                       hs_d1;
  logic                       vs_d1;
  logic [sel_bits-1:0]        sel_d1;

  always_ff @(posedge clk) begin
    if (reset || !scan_enable) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == h_total - 1) begin
      h_cnt <= '0;
      v_cnt <= (v_cnt == v_total - 1) ? '0 : v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign visible = scan_enable && (h_cnt < `FB_H_VISIBLE) && (v_cnt < `FB_V_VISIBLE);
  assign hs0 = !scan_enable || !(h_cnt >= hs_start && h_cnt < hs_start + `FB_H_SYNC);
  assign vs0 = !scan_enable || !(v_cnt >= vs_start && v_cnt < vs_start + `FB_V_SYNC);
  assign sel = sel_bits'(h_cnt % num_s);
  assign rd_addr = {fb_y_t'(v_cnt), fb_sx_t'(h_cnt / num_s)};

  for (genvar i = 0; i < num_s; i++) begin : g_rd
    assign rd_en[i] = visible && (sel == i);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      vis_d1  <= 1'b0;
      hs_d1   <= 1'b1;
      vs_d1   <= 1'b1;
      sel_d1  <= '0;
      vga_red <= '0;
      vga_grn <= '0;
      vga_blu <= '0;
      hsync   <= 1'b1;
      vsync   <= 1'b1;
    end else begin
      vis_d1  <= visible;
      hs_d1   <= hs0;
      vs_d1   <= vs0;
      sel_d1  <= sel;
      // blank outside the visible area
      vga_red <= vis_d1 ? rd_data[sel_d1].red : '0;
      vga_grn <= vis_d1 ? rd_data[sel_d1].grn : '0;
      vga_blu <= vis_d1 ? rd_data[sel_d1].blu : '0;
      hsync   <= hs_d1;
      vsync   <= vs_d1;
    end
  end

  // scanout never stops once the clear is done
  assert property (@(posedge clk) disable iff (reset) scan_enable |=> scan_enable);

endmodule

/* adc_xy_fb_top.sv */
`include "fb_config.svh"

module adc_xy_fb_top import fb_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       adc_valid,
  input  adc_t       adc_x,
  input  adc_t       adc_y,
  input  logic [2:0] adc_rgb,
  output logic       adc_ready,
  output color_t     vga_red,
  output color_t     vga_grn,
  output color_t     vga_blu,
  output logic       vga_hsync,
  output logic       vga_vsync
);

  localparam int num_s = `FB_NUM_STRIPES;

  gfx_if clear_if ();
  gfx_if draw_if ();
  gfx_if bank_if [num_s] ();

  logic             clear_last;
  logic             scan_enable;
  logic [num_s-1:0] rd_en;
  fb_addr_t         rd_addr;
  pixel_t           rd_data [num_s];

  gfx_clear u_clear (
    .clk  (clk),
    .reset(reset),
    .pix  (clear_if),
    .last (clear_last)
  );

  point_source u_source (
    .clk        (clk),
    .reset      (reset),
    .clear      (clear_if),
    .adc_valid  (adc_valid),
    .adc_x      (adc_x),
    .adc_y      (adc_y),
    .adc_rgb    (adc_rgb),
    .adc_ready  (adc_ready),
    .clear_last (clear_last),
    .draw       (draw_if),
    .scan_enable(scan_enable)
  );

  stripe_router u_router (
    .up   (draw_if),
    .banks(bank_if)
  );

  // one single-port bank per stripe
  for (genvar i = 0; i < num_s; i++) begin : g_stripe
    stripe_bank u_bank (
      .clk    (clk),
      .wr     (bank_if[i]),
      .rd_en  (rd_en[i]),
      .rd_addr(rd_addr),
      .rd_data(rd_data[i])
    );
  end

  scan_reader u_reader (
    .clk        (clk),
    .reset      (reset),
    .scan_enable(scan_enable),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .hsync      (vga_hsync),
    .vsync      (vga_vsync)
  );

endmodule

/* tb_adc_xy_fb.sv */
`include "fb_config.svh"

module tb_adc_xy_fb import fb_pkg::*; ();

  localparam int h_total      = `FB_H_VISIBLE + `FB_H_FRONT + `FB_H_SYNC + `FB_H_BACK;
  localparam int v_total      = `FB_V_VISIBLE + `FB_V_FRONT + `FB_V_SYNC + `FB_V_BACK;
  localparam int frame_cycles = h_total * v_total;
  localparam int clear_len    = `FB_H_VISIBLE * `FB_V_VISIBLE;
  localparam int period       = 20;
  localparam int timeout      = (40 * frame_cycles + clear_len + 4) * period;
  localparam int adc_max      = (1 << `FB_ADC_BITS) - 1;
  localparam int color_full   = (1 << `FB_COLOR_BITS) - 1;

  logic       clk;
  logic       reset;
  logic       adc_valid;
  adc_t       adc_x;
  adc_t       adc_y;
  logic [2:0] adc_rgb;
  logic       adc_ready;
  color_t     vga_red;
  color_t     vga_grn;
  color_t     vga_blu;
  logic       vga_hsync;
  logic       vga_vsync;

  pixel_t model [`FB_V_VISIBLE][`FB_H_VISIBLE];
  pixel_t seen;
  int     cycle = 0;
  int     ready_cycle = 0;
  int     quiet_cycles = 0;
  int     stall_cycles = 0;
  int     n_xfer = 0;
  int     failures = 0;
  int     frames_done = 0;
  int     vis_count = 0;
  int     line = 1000;
  int     pix_cnt = 0;
  int     px;
  int     hs_fall = 0;
  int     vs_fall = -1;
  logic   ready_seen = 1'b0;
  logic   hs_seen = 1'b0;
  logic   tracking = 1'b0;
  logic   compare_en = 1'b1;
  logic   hs_prev = 1'b1;
  logic   vs_prev = 1'b1;
  logic   in_vis;
  logic   offer_taken = 1'b1;
  adc_t   burst_x;
  adc_t   burst_y;

  adc_xy_fb_top dut0 (
    .clk      (clk),
    .reset    (reset),
    .adc_valid(adc_valid),
    .adc_x    (adc_x),
    .adc_y    (adc_y),
    .adc_rgb  (adc_rgb),
    .adc_ready(adc_ready),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync)
  );

  initial clk = 1'b0;
  always #(period / 2) clk = ~clk;

  task automatic stop_run();
    failures++;
    $display("TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_pixel(input string name, input pixel_t expected, input pixel_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_sync(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
      stop_run();
    end
  endtask

  // mirrored column, halved row, one flag per channel
  task automatic record_sample(input adc_t sx, input adc_t sy, input logic [2:0] rgb);
    int     col;
    int     row;
    pixel_t p;
    col = ((adc_max - int'(sx)) / 2) % `FB_H_VISIBLE;
    row = (int'(sy) / 2) % `FB_V_VISIBLE;
    p.red = rgb[2] ? color_t'(color_full) : '0;
    p.grn = rgb[1] ? color_t'(color_full) : '0;
    p.blu = rgb[0] ? color_t'(color_full) : '0;
    model[row][col] = p;
  endtask

  // one stimulus cycle, a refused sample stays on the bus
  task automatic step_adc(input int valid_pct, input logic fixed_xy);
    @(posedge clk);
    #1;
    if (!adc_valid || offer_taken) begin
      adc_valid = int'($urandom % 100) < valid_pct;
      adc_rgb   = 3'($urandom);
      adc_x     = fixed_xy ? burst_x : adc_t'($urandom);
      adc_y     = fixed_xy ? burst_y : adc_t'($urandom);
    end
    offer_taken = adc_ready;
  endtask

  task automatic release_adc();
    do begin
      step_adc(0, 1'b0);
    end while (adc_valid);
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = frames_done + n;
    wait (frames_done >= target);
  endtask

  // port monitor, sampled away from the rising edge
  always @(negedge clk) begin
    if (!reset) begin
      cycle++;
      if (adc_valid && adc_ready) begin
        record_sample(adc_x, adc_y, adc_rgb);
        n_xfer++;
      end
      if (!ready_seen) begin
        if (adc_ready) begin
          ready_seen  = 1'b1;
          ready_cycle = cycle;
          check_count("clear_cycles", clear_len, quiet_cycles);
        end else begin
          quiet_cycles++;
        end
      end else if (!adc_ready) begin
        stall_cycles++;
      end

      if (hs_prev && !vga_hsync) begin
        if (!hs_seen) begin
          check_count("first_hsync_delay", `FB_H_VISIBLE + `FB_H_FRONT + 2, cycle - ready_cycle);
        end else begin
          check_count("hsync_period", h_total, cycle - hs_fall);
        end
        hs_seen = 1'b1;
        hs_fall = cycle;
      end
      if (vs_prev && !vga_vsync) begin
        if (vs_fall >= 0) begin
          check_count("vsync_period", frame_cycles, cycle - vs_fall);
        end
        vs_fall = cycle;
      end
      // back porch line follows the vsync pulse, next hsync rise opens line 0
      if (!vs_prev && vga_vsync) begin
        check_count("vsync_width", `FB_V_SYNC * h_total, cycle - vs_fall);
        tracking  = 1'b1;
        line      = -1;
        vis_count = 0;
      end
      if (!hs_prev && vga_hsync) begin
        check_count("hsync_width", `FB_H_SYNC, cycle - hs_fall);
        pix_cnt = 0;
        line++;
      end else begin
        pix_cnt++;
      end
      hs_prev = vga_hsync;
      vs_prev = vga_vsync;

      seen.red = vga_red;
      seen.grn = vga_grn;
      seen.blu = vga_blu;
      px       = pix_cnt - `FB_H_BACK;
      in_vis   = tracking && line >= 0 && line < `FB_V_VISIBLE && px >= 0 && px < `FB_H_VISIBLE;
      if (!hs_seen) begin
        check_sync("vsync_before_scan", 1'b1, vga_vsync);
        check_pixel("colour_before_scan", '0, seen);
      end else if (tracking && !in_vis) begin
        check_pixel("blanking", '0, seen);
      end else if (in_vis) begin
        check_sync("vsync_in_visible", 1'b1, vga_vsync);
        vis_count++;
        if (compare_en) begin
          check_pixel($sformatf("frame %0d pixel (%0d,%0d)", frames_done + 1, px, line),
                      model[line][px], seen);
        end
        if (line == `FB_V_VISIBLE - 1 && px == `FB_H_VISIBLE - 1) begin
          check_count("visible_pixels", clear_len, vis_count);
          frames_done++;
        end
      end
    end
  end

  initial begin
    #(timeout);
    $display("watchdog expired after %0d time units, the run did not finish", timeout);
    $display("TESTS FAILED");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    void'($urandom(82));
    reset     = 1'b1;
    adc_valid = 1'b0;
    adc_x     = '0;
    adc_y     = '0;
    adc_rgb   = '0;
    for (int r = 0; r < `FB_V_VISIBLE; r++) begin
      for (int c = 0; c < `FB_H_VISIBLE; c++) begin
        model[r][c] = '0;
      end
    end
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    // samples offered while clearing must all be refused
    repeat (clear_len) begin
      adc_valid = 1'($urandom);
      adc_x     = adc_t'($urandom);
      adc_y     = adc_t'($urandom);
      adc_rgb   = 3'($urandom);
      @(posedge clk);
      #1;
    end
    adc_valid = 1'b0;

    // first complete frame is black
    wait_frames(1);
    compare_en = 1'b0;
    check_count("transfers_before_draw", 0, n_xfer);

    while (frames_done < 5) begin
      step_adc(50, 1'b0);
    end
    release_adc();
    wait_frames(2);
    compare_en = 1'b1;
    wait_frames(1);
    compare_en = 1'b0;

    // overwrite one pixel while scanout reads its bank
    burst_x = adc_t'($urandom);
    burst_y = adc_t'($urandom);
    do begin
      @(posedge clk);
    end while (!(line >= 0 && line < `FB_V_VISIBLE / 2 && pix_cnt == `FB_H_BACK));
    repeat (8) step_adc(100, 1'b1);
    release_adc();
    wait_frames(2);
    compare_en = 1'b1;
    wait_frames(1);
    compare_en = 1'b0;

    if (stall_cycles == 0) begin
      $display("adc_ready never went low while the source held a pending write");
      stop_run();
    end
    if (failures == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "errors were reported");
    end
  end

endmodule

/* filelist.f */
+incdir+.
fb_pkg.sv
gfx_if.sv
gfx_clear.sv
point_source.sv
stripe_router.sv
stripe_bank.sv
scan_reader.sv
adc_xy_fb_top.sv
tb_adc_xy_fb.sv

/* run.sh */
#!/bin/sh
# compile and run the adc_xy_fb testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module tb_adc_xy_fb -o tb_adc_xy_fb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_adc_xy_fb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0
